// File: Bender.yml
package:
  name: cache_subsystem

export_include_dirs:
  - .

sources:
  - files:
      - mem_pkg.sv
      - cache_pkg.sv
      - cache_array.sv
      - cache_ctrl.sv
      - backing_mem.sv
      - perf_counter.sv
      - uart_tx.sv
      - cache_top.sv
  - target: test
    files:
      - cache_tb.sv

// File: backing_mem.sv
`timescale 1ns/1ps
`include "cache_cfg.svh"

module backing_mem (
	input  logic              clk,
	input  logic              rst,
	input  logic              i_req,
	input  mem_pkg::addr_t    i_addr,
	output logic              i_ack,
	output mem_pkg::data_t    i_rdata,
	input  logic              d_req,
	input  mem_pkg::mem_op_e  d_op,
	input  mem_pkg::addr_t    d_addr,
	input  mem_pkg::data_t    d_wdata,
	input  mem_pkg::strobe_t  d_strobe,
	output logic              d_ack,
	output mem_pkg::data_t    d_rdata
);

	localparam int AW = $clog2(`MEM_WORDS);

	mem_pkg::data_t mem [`MEM_WORDS];

	logic busy;
	logic grant_d;
	logic [3:0] lat_cnt;
	logic accept;
	logic done;
	logic [AW-1:0] addr_q;
	mem_pkg::mem_op_e op_q;
	mem_pkg::data_t wdata_q;
	mem_pkg::strobe_t strobe_q;
	mem_pkg::data_t rdata_q;

	// no new accept while an ack is out, the port still holds its old request
	assign accept = !busy && !i_ack && !d_ack && (i_req || d_req);
	assign done   = busy && (lat_cnt == '0);

	always_ff @(posedge clk) begin
		if (rst) begin
			busy    <= 1'b0;
			grant_d <= 1'b0;
			lat_cnt <= '0;
			i_ack   <= 1'b0;
			d_ack   <= 1'b0;
		end else begin
			i_ack <= 1'b0;
			d_ack <= 1'b0;
			if (accept) begin
				busy    <= 1'b1;
				grant_d <= !i_req; // instruction side wins
				lat_cnt <= 4'(`MEM_LATENCY - 1);
			end else if (done) begin
				busy <= 1'b0;
				if (grant_d) begin
					d_ack <= 1'b1;
				end else begin
					i_ack <= 1'b1;
				end
			end else if (busy) begin
				lat_cnt <= lat_cnt - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			addr_q   <= i_req ? i_addr[AW+1:2] : d_addr[AW+1:2];
			op_q     <= i_req ? mem_pkg::MEM_READ : d_op;
			wdata_q  <= d_wdata;
			strobe_q <= d_strobe;
		end
		if (done) begin
			rdata_q <= mem[addr_q];
			if (op_q == mem_pkg::MEM_WRITE) begin
				for (int b = 0; b < 4; b++) begin
					if (strobe_q[b]) begin
						mem[addr_q][8*b +: 8] <= wdata_q[8*b +: 8];
					end
				end
			end
		end
	end

	assign i_rdata = rdata_q;
	assign d_rdata = rdata_q;

endmodule

// File: cache_array.sv
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_array (
	input  logic                          clk,
	input  logic                          rst,
	input  logic [`CACHE_INDEX_BITS-1:0]  index,
	input  logic [`CACHE_OFFSET_BITS-1:0] offset,
	output logic [`CACHE_TAG_BITS-1:0]    rd_tag,
	output logic                          rd_valid,
	output mem_pkg::data_t                rd_word,
	input  logic                          fill_en,
	input  logic [`CACHE_TAG_BITS-1:0]    fill_tag,
	input  mem_pkg::data_t                fill_word,
	input  logic                          fill_last,
	input  logic                          wr_en,
	input  mem_pkg::data_t                wr_word,
	input  mem_pkg::strobe_t              wr_strobe
);

	localparam int LINES = 1 << `CACHE_INDEX_BITS;
	localparam int WORDS = LINES * `CACHE_WORDS_PER_LINE;

	logic [`CACHE_TAG_BITS-1:0] tag_mem [LINES];
	mem_pkg::data_t data_mem [WORDS];
	logic [LINES-1:0] valid;

	always_ff @(posedge clk) begin
		if (rst) begin
			valid <= '0;
		end else if (fill_en) begin
			valid[index] <= fill_last; // line is invalid while partly filled
		end
	end

	always_ff @(posedge clk) begin
		if (fill_en && fill_last) begin
			tag_mem[index] <= fill_tag;
		end
		if (fill_en) begin
			data_mem[{index, offset}] <= fill_word;
		end else if (wr_en) begin
			for (int b = 0; b < 4; b++) begin
				if (wr_strobe[b]) begin
					data_mem[{index, offset}][8*b +: 8] <= wr_word[8*b +: 8];
				end
			end
		end
	end

	// registered lookup
	always_ff @(posedge clk) begin
		rd_tag   <= tag_mem[index];
		rd_valid <= valid[index];
		rd_word  <= data_mem[{index, offset}];
	end

endmodule

// File: cache_cfg.svh
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// cache geometry
`define CACHE_WORDS_PER_LINE	4
`define CACHE_INDEX_BITS	4
`define CACHE_OFFSET_BITS	($clog2(`CACHE_WORDS_PER_LINE))
`define CACHE_TAG_BITS	(32 - `CACHE_INDEX_BITS - `CACHE_OFFSET_BITS - 2)

// last word address of the instruction region
`define END_INST	32'h0000_00FC

// backing memory
`define MEM_LATENCY	3
`define MEM_WORDS	256

// serial port
`define UART_CLKS_PER_BIT	8

`endif

// File: cache_ctrl.sv
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_ctrl (
	input  logic              clk,
	input  logic              rst,
	input  mem_pkg::addr_t    req_addr,
	input  logic              req_read,
	input  logic              req_write,
	input  mem_pkg::data_t    req_wdata,
	input  mem_pkg::strobe_t  req_strobe,
	output mem_pkg::data_t    rdata,
	output logic              read_response,
	output logic              write_response,
	output logic              mem_req,
	output mem_pkg::mem_op_e  mem_op,
	output mem_pkg::addr_t    mem_addr,
	output mem_pkg::data_t    mem_wdata,
	output mem_pkg::strobe_t  mem_strobe,
	input  logic              mem_ack,
	input  mem_pkg::data_t    mem_rdata,
	output logic              ev_access,
	output logic              ev_miss,
	output logic              ev_write
);

	localparam int OFF_W = `CACHE_OFFSET_BITS;
	localparam int TAG_W = `CACHE_TAG_BITS;

	cache_pkg::ctrl_state_e state;
	logic write_q;
	logic miss_q;
	logic [OFF_W-1:0] fill_cnt;
	mem_pkg::data_t rdata_q;

	logic [TAG_W-1:0] req_tag;
	logic [`CACHE_INDEX_BITS-1:0] req_index;
	logic [OFF_W-1:0] req_off;
	logic [OFF_W-1:0] arr_offset;
	logic [TAG_W-1:0] rd_tag;
	logic rd_valid;
	mem_pkg::data_t rd_word;
	logic hit;
	logic fill_en;
	logic fill_last;
	logic wr_en;

	assign req_tag   = req_addr[31 -: TAG_W];
	assign req_index = req_addr[2 + OFF_W +: `CACHE_INDEX_BITS];
	assign req_off   = req_addr[2 +: OFF_W];

	assign hit        = rd_valid && (rd_tag == req_tag);
	assign arr_offset = (state == cache_pkg::ST_REFILL) ? fill_cnt : req_off;
	assign fill_en    = (state == cache_pkg::ST_REFILL) && mem_ack;
	assign fill_last  = fill_cnt == OFF_W'(`CACHE_WORDS_PER_LINE - 1);
	assign wr_en      = (state == cache_pkg::ST_LOOKUP) && write_q && hit; // write hit merges

	cache_array u_array (
		.clk       (clk),
		.rst       (rst),
		.index     (req_index),
		.offset    (arr_offset),
		.rd_tag    (rd_tag),
		.rd_valid  (rd_valid),
		.rd_word   (rd_word),
		.fill_en   (fill_en),
		.fill_tag  (req_tag),
		.fill_word (mem_rdata),
		.fill_last (fill_last),
		.wr_en     (wr_en),
		.wr_word   (req_wdata),
		.wr_strobe (req_strobe)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= cache_pkg::ST_IDLE;
			write_q  <= 1'b0;
			miss_q   <= 1'b0;
			fill_cnt <= '0;
		end else begin
			case (state)
				cache_pkg::ST_IDLE: begin
					if (req_read || req_write) begin
						state   <= cache_pkg::ST_LOOKUP;
						write_q <= req_write;
						miss_q  <= 1'b0;
					end
				end
				cache_pkg::ST_LOOKUP: begin
					if (write_q) begin
						state <= cache_pkg::ST_WRITE; // no allocate on write miss
					end else if (hit) begin
						state <= cache_pkg::ST_RESPOND;
					end else begin
						state    <= cache_pkg::ST_REFILL;
						miss_q   <= 1'b1;
						fill_cnt <= '0;
					end
				end
				cache_pkg::ST_REFILL: begin
					if (mem_ack) begin
						fill_cnt <= fill_cnt + 1'b1;
						if (fill_last) begin
							state <= cache_pkg::ST_RESPOND;
						end
					end
				end
				cache_pkg::ST_WRITE: begin
					if (mem_ack) begin
						state <= cache_pkg::ST_RESPOND;
					end
				end
				default: state <= cache_pkg::ST_IDLE;
			endcase
		end
	end

	// answer word, from the array on a hit or caught during refill
	always_ff @(posedge clk) begin
		if (state == cache_pkg::ST_LOOKUP) begin
			rdata_q <= rd_word;
		end else if (fill_en && (fill_cnt == req_off)) begin
			rdata_q <= mem_rdata;
		end
	end

	assign rdata          = rdata_q;
	assign read_response  = (state == cache_pkg::ST_RESPOND) && !write_q;
	assign write_response = (state == cache_pkg::ST_RESPOND) && write_q;

	assign mem_req    = (state == cache_pkg::ST_REFILL) || (state == cache_pkg::ST_WRITE);
	assign mem_op     = (state == cache_pkg::ST_WRITE) ? mem_pkg::MEM_WRITE : mem_pkg::MEM_READ;
	assign mem_addr   = (state == cache_pkg::ST_WRITE) ? {req_addr[31:2], 2'b00}
	                                                   : {req_tag, req_index, fill_cnt, 2'b00};
	assign mem_wdata  = req_wdata;
	assign mem_strobe = req_strobe;

	assign ev_access = state == cache_pkg::ST_RESPOND;
	assign ev_miss   = (state == cache_pkg::ST_RESPOND) && miss_q;
	assign ev_write  = (state == cache_pkg::ST_RESPOND) && write_q;

endmodule

// File: cache_pkg.sv
package cache_pkg;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LOOKUP,
		ST_REFILL,
		ST_WRITE,
		ST_RESPOND
	} ctrl_state_e;

	// order is the order bytes leave on the uart
	typedef enum logic [2:0] {
		SEL_I_ACCESS,
		SEL_I_MISS,
		SEL_D_ACCESS,
		SEL_D_WRITE,
		SEL_D_MISS
	} stat_sel_e;

endpackage

// File: cache_tb.sv
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_tb;

	typedef enum logic [1:0] {
		OP_READ,
		OP_WRITE,
		OP_DUMP
	} tb_op_e;

	localparam int MAX_ENTRIES = 64;
	localparam int NUM_RAND = 8;
	localparam int LINES = 1 << `CACHE_INDEX_BITS;
	localparam int FRAME_CYCLES = 10 * `UART_CLKS_PER_BIT;
	localparam int C_I_ACCESS = 0;
	localparam int C_I_MISS = 1;
	localparam int C_D_ACCESS = 2;
	localparam int C_D_WRITE = 3;
	localparam int C_D_MISS = 4;

	logic clk;
	logic rst;
	mem_pkg::addr_t rw_address;
	logic read_request;
	logic write_request;
	mem_pkg::data_t write_data;
	mem_pkg::strobe_t write_strobe;
	mem_pkg::data_t read_data;
	logic read_response;
	logic write_response;
	logic dump;
	logic dumping;
	logic tx;

	string t_name [MAX_ENTRIES];
	tb_op_e t_op [MAX_ENTRIES];
	logic [31:0] t_addr [MAX_ENTRIES];
	logic [31:0] t_data [MAX_ENTRIES]; // for a dump, bit 0 asks for a second pulse
	logic [3:0] t_strobe [MAX_ENTRIES];
	logic [31:0] t_exp [MAX_ENTRIES];
	int n_entries;
	int n_dumps;

	logic [31:0] model_mem [`MEM_WORDS];
	logic [31:0] i_tag [LINES];
	logic i_valid [LINES];
	logic [31:0] d_tag [LINES];
	logic d_valid [LINES];
	logic [15:0] exp_cnt [5];
	string cnt_name [5] = '{"i_access", "i_miss", "d_access", "d_write", "d_miss"};

	logic [7:0] rx_bytes [$];
	int errors;
	int cycles;
	int cycle_limit;
	logic [31:0] lcg_state;

	cache_top cache_top_inst (
		.clk            (clk),
		.rst            (rst),
		.rw_address     (rw_address),
		.read_request   (read_request),
		.write_request  (write_request),
		.write_data     (write_data),
		.write_strobe   (write_strobe),
		.read_data      (read_data),
		.read_response  (read_response),
		.write_response (write_response),
		.dump           (dump),
		.dumping        (dumping),
		.tx             (tx)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
			input logic [31:0] new_word, input logic [3:0] strobe);
		logic [31:0] mask;
		mask = {{8{strobe[3]}}, {8{strobe[2]}}, {8{strobe[1]}}, {8{strobe[0]}}};
		return (old_word & ~mask) | (new_word & mask);
	endfunction

	function automatic int line_index(input logic [31:0] addr);
		return (addr >> (2 + `CACHE_OFFSET_BITS)) % LINES;
	endfunction

	function automatic logic [31:0] line_tag(input logic [31:0] addr);
		return addr >> (2 + `CACHE_OFFSET_BITS + `CACHE_INDEX_BITS);
	endfunction

	// expected read words come from the model as the table is built
	task automatic add_entry(input string name, input tb_op_e op, input logic [31:0] addr,
			input logic [31:0] data, input logic [3:0] strobe);
		int w;
		w = (addr >> 2) % `MEM_WORDS;
		t_name[n_entries] = name;
		t_op[n_entries] = op;
		t_addr[n_entries] = addr;
		t_data[n_entries] = data;
		t_strobe[n_entries] = strobe;
		t_exp[n_entries] = '0;
		if (op == OP_WRITE) begin
			model_mem[w] = merge_bytes(model_mem[w], data, strobe);
		end else if (op == OP_READ) begin
			t_exp[n_entries] = model_mem[w];
		end else begin
			n_dumps++;
		end
		n_entries++;
	endtask

	task automatic build_table();
		logic [31:0] rand_addr [NUM_RAND];
		n_entries = 0;
		n_dumps = 0;
		for (int i = 0; i < LINES; i++) begin
			i_valid[i] = 1'b0;
			d_valid[i] = 1'b0;
		end
		for (int i = 0; i < 5; i++) begin
			exp_cnt[i] = '0;
		end
		add_entry("b1_write", OP_WRITE, 32'h100, 32'hA5A5_0001, 4'hF);
		add_entry("b1_read_miss", OP_READ, 32'h100, 32'h0, 4'h0);
		add_entry("b1_read_hit", OP_READ, 32'h100, 32'h0, 4'h0);
		add_entry("b1_dump", OP_DUMP, 32'h0, 32'h0, 4'h0);
		add_entry("b2_write_full", OP_WRITE, 32'h120, 32'h1122_3344, 4'hF);
		add_entry("b2_read_fill", OP_READ, 32'h120, 32'h0, 4'h0);
		add_entry("b2_write_byte", OP_WRITE, 32'h120, 32'h0000_00EE, 4'b0001);
		add_entry("b2_write_half", OP_WRITE, 32'h120, 32'hBEEF_0000, 4'b1100);
		add_entry("b2_read_merged", OP_READ, 32'h120, 32'h0, 4'h0);
		add_entry("b2_write_conflict", OP_WRITE, 32'h220, 32'h5555_AAAA, 4'hF);
		add_entry("b2_read_conflict", OP_READ, 32'h220, 32'h0, 4'h0); // evicts 0x120
		add_entry("b2_read_evicted", OP_READ, 32'h120, 32'h0, 4'h0);
		add_entry("b3_write_i0", OP_WRITE, 32'h000, 32'h0000_0013, 4'hF);
		add_entry("b3_write_i1", OP_WRITE, 32'h004, 32'h00A0_0093, 4'hF);
		add_entry("b3_write_i2", OP_WRITE, 32'h0F0, 32'hFFDF_F06F, 4'hF);
		add_entry("b3_write_iend", OP_WRITE, `END_INST, 32'h0000_8067, 4'hF);
		add_entry("b3_read_i0", OP_READ, 32'h000, 32'h0, 4'h0);
		add_entry("b3_read_i1", OP_READ, 32'h004, 32'h0, 4'h0);
		add_entry("b3_read_i0_again", OP_READ, 32'h000, 32'h0, 4'h0);
		add_entry("b3_read_iend", OP_READ, `END_INST, 32'h0, 4'h0);
		for (int i = 0; i < 4; i++) begin
			add_entry($sformatf("b4_write_w%0d", i), OP_WRITE, 32'h180 + 4 * i,
				32'hC0DE_0000 + i, 4'hF);
		end
		for (int i = 0; i < 4; i++) begin
			add_entry($sformatf("b4_read_w%0d", i), OP_READ, 32'h180 + 4 * i, 32'h0, 4'h0);
		end
		lcg_state = 32'h59f1;
		for (int i = 0; i < NUM_RAND; i++) begin
			lcg_state = lcg_next(lcg_state);
			rand_addr[i] = 32'h300 + {lcg_state[21:16], 2'b00};
			lcg_state = lcg_next(lcg_state);
			add_entry($sformatf("rand_write_%0d", i), OP_WRITE, rand_addr[i], lcg_state, 4'hF);
		end
		for (int i = 0; i < NUM_RAND; i++) begin
			add_entry($sformatf("rand_read_%0d", i), OP_READ, rand_addr[i], 32'h0, 4'h0);
		end
		add_entry("b5_dump_twice", OP_DUMP, 32'h0, 32'h1, 4'h0);
		cycle_limit = 2 * (40 + n_entries * (4 * (`MEM_LATENCY + 2) + 8)
			+ n_dumps * (10 * (FRAME_CYCLES + 4) + 3 * FRAME_CYCLES));
	endtask

	task automatic run_access(input int k);
		int waited;
		int idx;
		logic [31:0] tag;
		logic inst;
		logic hit;
		idx = line_index(t_addr[k]);
		tag = line_tag(t_addr[k]);
		inst = t_addr[k] <= `END_INST;
		hit = 1'b0;
		if (t_op[k] == OP_READ) begin
			hit = inst ? (i_valid[idx] && i_tag[idx] == tag) : (d_valid[idx] && d_tag[idx] == tag);
		end
		rw_address = t_addr[k];
		write_data = t_data[k];
		write_strobe = t_strobe[k];
		read_request = t_op[k] == OP_READ;
		write_request = t_op[k] == OP_WRITE;
		@(negedge clk);
		waited = 1;
		while (read_response !== 1'b1 && write_response !== 1'b1) begin
			@(negedge clk);
			waited++;
		end
		if (t_op[k] == OP_WRITE) begin
			if (write_response !== 1'b1 || read_response !== 1'b0) begin
				errors++;
				$display("%s: a write got a read response", t_name[k]);
			end
			exp_cnt[C_D_ACCESS]++;
			exp_cnt[C_D_WRITE]++;
		end else begin
			if (read_response !== 1'b1 || write_response !== 1'b0) begin
				errors++;
				$display("%s: a read got a write response", t_name[k]);
			end
			if (read_data !== t_exp[k]) begin
				errors++;
				$display("Fail %s expected %h actual %h", t_name[k], t_exp[k], read_data);
			end
			if (hit && waited != 2) begin
				errors++;
				$display("Fail %s hit latency expected %0d actual %0d", t_name[k], 2, waited);
			end
			if (!hit && waited < 4 * (`MEM_LATENCY + 1)) begin
				errors++;
				$display("Fail %s miss latency expected %0d actual %0d", t_name[k],
					4 * (`MEM_LATENCY + 1), waited);
			end
			exp_cnt[inst ? C_I_ACCESS : C_D_ACCESS]++;
			if (!hit && inst) begin
				exp_cnt[C_I_MISS]++;
				i_valid[idx] = 1'b1;
				i_tag[idx] = tag;
			end else if (!hit) begin
				exp_cnt[C_D_MISS]++;
				d_valid[idx] = 1'b1;
				d_tag[idx] = tag;
			end
		end
		read_request = 1'b0;
		write_request = 1'b0;
		@(negedge clk);
		if (read_response !== 1'b0 || write_response !== 1'b0) begin
			errors++;
			$display("%s: response stayed high for more than one cycle", t_name[k]);
		end
	endtask

	task automatic run_dump(input int k);
		logic [15:0] got;
		rx_bytes.delete();
		dump = 1'b1;
		@(negedge clk);
		dump = 1'b0;
		if (t_data[k][0]) begin
			repeat (FRAME_CYCLES / 2) @(negedge clk);
			if (dumping !== 1'b1) begin
				errors++;
				$display("%s: dumping low before the second dump pulse", t_name[k]);
			end
			dump = 1'b1; // must be ignored mid-send
			@(negedge clk);
			dump = 1'b0;
		end
		while (dumping === 1'b1) @(negedge clk);
		repeat (2 * FRAME_CYCLES) @(negedge clk); // room for a stray frame
		if (rx_bytes.size() != 10) begin
			errors++;
			$display("Fail %s byte count expected %0d actual %0d", t_name[k], 10,
				rx_bytes.size());
		end else begin
			for (int i = 0; i < 5; i++) begin
				got = {rx_bytes[2 * i + 1], rx_bytes[2 * i]}; // low byte first
				if (got !== exp_cnt[i]) begin
					errors++;
					$display("Fail %s %s expected %h actual %h", t_name[k], cnt_name[i],
						exp_cnt[i], got);
				end
			end
		end
		if (tx !== 1'b1) begin
			errors++;
			$display("%s: tx not idle high after the dump", t_name[k]);
		end
	endtask

	// serial decoder, samples mid-bit
	initial begin : uart_decoder
		logic [7:0] b;
		wait (rst === 1'b0);
		forever begin
			@(negedge tx);
			repeat (`UART_CLKS_PER_BIT / 2) @(negedge clk);
			if (tx !== 1'b0) begin
				errors++;
				$display("uart start bit did not last half a bit time");
			end
			for (int i = 0; i < 8; i++) begin
				repeat (`UART_CLKS_PER_BIT) @(negedge clk);
				b[i] = tx;
			end
			repeat (`UART_CLKS_PER_BIT) @(negedge clk);
			if (tx !== 1'b1) begin
				errors++;
				$display("uart stop bit missing");
			end
			rx_bytes.push_back(b);
		end
	end

	initial begin : watchdog
		cycles = 0;
		wait (cycle_limit > 0);
		while (cycles <= cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles, a response or the dump never finished", cycles);
		$display("errors: %0d", errors);
		$display("test failed");
		$finish;
	end

	initial begin : main
		rst = 1'b1;
		rw_address = '0;
		read_request = 1'b0;
		write_request = 1'b0;
		write_data = '0;
		write_strobe = '0;
		dump = 1'b0;
		errors = 0;
		cycle_limit = 0;
		build_table();
		repeat (5) @(negedge clk);
		rst = 1'b0;
		repeat (8) begin
			@(negedge clk);
			if (read_response !== 1'b0 || write_response !== 1'b0 || dumping !== 1'b0) begin
				errors++;
				$display("response or dumping active after reset before any request");
			end
			if (tx !== 1'b1) begin
				errors++;
				$display("tx not high after reset");
			end
		end
		for (int k = 0; k < n_entries; k++) begin
			if (t_op[k] == OP_DUMP) begin
				run_dump(k);
			end else begin
				run_access(k);
			end
		end
		$display("entries: %0d, errors: %0d", n_entries, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// File: cache_top.sv
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_top (
	input  logic              clk,
	input  logic              rst,
	input  mem_pkg::addr_t    rw_address,
	input  logic              read_request,
	input  logic              write_request,
	input  mem_pkg::data_t    write_data,
	input  mem_pkg::strobe_t  write_strobe,
	output mem_pkg::data_t    read_data,
	output logic              read_response,
	output logic              write_response,
	input  logic              dump,
	output logic              dumping,
	output logic              tx
);

	logic is_inst;
	logic i_read;
	logic d_read;

	mem_pkg::data_t i_rdata;
	mem_pkg::data_t d_rdata;
	logic i_read_response;
	logic d_read_response;

	logic i_mem_req;
	mem_pkg::addr_t i_mem_addr;
	logic i_mem_ack;
	mem_pkg::data_t i_mem_rdata;

	logic d_mem_req;
	mem_pkg::mem_op_e d_mem_op;
	mem_pkg::addr_t d_mem_addr;
	mem_pkg::data_t d_mem_wdata;
	mem_pkg::strobe_t d_mem_strobe;
	logic d_mem_ack;
	mem_pkg::data_t d_mem_rdata;

	logic i_ev_access;
	logic i_ev_miss;
	logic d_ev_access;
	logic d_ev_miss;
	logic d_ev_write;

	logic [7:0] tx_byte;
	logic tx_start;
	logic tx_busy;

	// writes always take the data side
	assign is_inst = rw_address <= `END_INST;
	assign i_read  = read_request && is_inst;
	assign d_read  = read_request && !is_inst;

	assign read_data     = i_read_response ? i_rdata : d_rdata;
	assign read_response = i_read_response || d_read_response;

	cache_ctrl u_icache (
		.clk            (clk),
		.rst            (rst),
		.req_addr       (rw_address),
		.req_read       (i_read),
		.req_write      (1'b0),
		.req_wdata      ('0),
		.req_strobe     ('0),
		.rdata          (i_rdata),
		.read_response  (i_read_response),
		.write_response (),
		.mem_req        (i_mem_req),
		.mem_op         (),
		.mem_addr       (i_mem_addr),
		.mem_wdata      (),
		.mem_strobe     (),
		.mem_ack        (i_mem_ack),
		.mem_rdata      (i_mem_rdata),
		.ev_access      (i_ev_access),
		.ev_miss        (i_ev_miss),
		.ev_write       ()
	);

	cache_ctrl u_dcache (
		.clk            (clk),
		.rst            (rst),
		.req_addr       (rw_address),
		.req_read       (d_read),
		.req_write      (write_request),
		.req_wdata      (write_data),
		.req_strobe     (write_strobe),
		.rdata          (d_rdata),
		.read_response  (d_read_response),
		.write_response (write_response),
		.mem_req        (d_mem_req),
		.mem_op         (d_mem_op),
		.mem_addr       (d_mem_addr),
		.mem_wdata      (d_mem_wdata),
		.mem_strobe     (d_mem_strobe),
		.mem_ack        (d_mem_ack),
		.mem_rdata      (d_mem_rdata),
		.ev_access      (d_ev_access),
		.ev_miss        (d_ev_miss),
		.ev_write       (d_ev_write)
	);

	backing_mem u_mem (
		.clk      (clk),
		.rst      (rst),
		.i_req    (i_mem_req),
		.i_addr   (i_mem_addr),
		.i_ack    (i_mem_ack),
		.i_rdata  (i_mem_rdata),
		.d_req    (d_mem_req),
		.d_op     (d_mem_op),
		.d_addr   (d_mem_addr),
		.d_wdata  (d_mem_wdata),
		.d_strobe (d_mem_strobe),
		.d_ack    (d_mem_ack),
		.d_rdata  (d_mem_rdata)
	);

	perf_counter u_perf (
		.clk      (clk),
		.rst      (rst),
		.i_access (i_ev_access),
		.i_miss   (i_ev_miss),
		.d_access (d_ev_access),
		.d_write  (d_ev_write),
		.d_miss   (d_ev_miss),
		.dump     (dump),
		.tx_byte  (tx_byte),
		.tx_start (tx_start),
		.tx_busy  (tx_busy),
		.dumping  (dumping)
	);

	uart_tx u_uart (
		.clk      (clk),
		.rst      (rst),
		.tx_byte  (tx_byte),
		.tx_start (tx_start),
		.busy     (tx_busy),
		.tx       (tx)
	);

endmodule

// File: mem_pkg.sv
package mem_pkg;

	// byte address, always word aligned on the memory side
	typedef logic [31:0] addr_t;

	typedef logic [31:0] data_t;

	typedef logic [3:0] strobe_t; // one bit per byte lane

	typedef enum logic {
		MEM_READ,
		MEM_WRITE
	} mem_op_e;

endpackage

// File: perf_counter.sv
`timescale 1ns/1ps

module perf_counter (
	input  logic       clk,
	input  logic       rst,
	input  logic       i_access,
	input  logic       i_miss,
	input  logic       d_access,
	input  logic       d_write,
	input  logic       d_miss,
	input  logic       dump,
	output logic [7:0] tx_byte,
	output logic       tx_start,
	input  logic       tx_busy,
	output logic       dumping
);

	localparam int NUM_STATS = int'(cache_pkg::SEL_D_MISS) + 1;

	logic [15:0] cnt [NUM_STATS];
	logic [15:0] snap [NUM_STATS];
	logic [NUM_STATS-1:0] ev;
	cache_pkg::stat_sel_e sel;
	logic hi;
	logic last_sent;

	assign ev = {d_miss, d_write, d_access, i_miss, i_access}; // matches stat_sel_e

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_STATS; i++) begin
				cnt[i] <= '0;
			end
		end else begin
			for (int i = 0; i < NUM_STATS; i++) begin
				if (ev[i] && (cnt[i] != 16'hffff)) begin
					cnt[i] <= cnt[i] + 16'd1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!dumping && dump) begin
			snap <= cnt;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			dumping   <= 1'b0;
			tx_start  <= 1'b0;
			sel       <= cache_pkg::SEL_I_ACCESS;
			hi        <= 1'b0;
			last_sent <= 1'b0;
		end else begin
			tx_start <= 1'b0;
			if (!dumping) begin
				if (dump) begin
					dumping   <= 1'b1;
					sel       <= cache_pkg::SEL_I_ACCESS;
					hi        <= 1'b0;
					last_sent <= 1'b0;
				end
			end else if (!tx_busy && !tx_start) begin
				if (last_sent) begin
					dumping <= 1'b0; // last frame has left the uart
				end else begin
					tx_start <= 1'b1;
					hi       <= !hi;
					if (hi) begin
						if (sel == cache_pkg::SEL_D_MISS) begin
							last_sent <= 1'b1;
						end else begin
							sel <= cache_pkg::stat_sel_e'(sel + 3'd1);
						end
					end
				end
			end
		end
	end

	// low byte first
	always_ff @(posedge clk) begin
		if (dumping && !tx_busy && !tx_start && !last_sent) begin
			tx_byte <= hi ? snap[sel][15:8] : snap[sel][7:0];
		end
	end

endmodule

// File: project.f
+incdir+.
mem_pkg.sv
cache_pkg.sv
cache_array.sv
cache_ctrl.sv
backing_mem.sv
perf_counter.sv
uart_tx.sv
cache_top.sv
cache_tb.sv

// File: uart_tx.sv
`timescale 1ns/1ps
`include "cache_cfg.svh"

module uart_tx (
	input  logic       clk,
	input  logic       rst,
	input  logic [7:0] tx_byte,
	input  logic       tx_start,
	output logic       busy,
	output logic       tx
);

	localparam int DIV_W = $clog2(`UART_CLKS_PER_BIT);

	logic [DIV_W-1:0] div;
	logic [3:0] bitn;
	logic [8:0] shreg; // data bits then stop bit

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			tx   <= 1'b1;
			div  <= '0;
			bitn <= '0;
		end else if (!busy) begin
			if (tx_start) begin
				busy <= 1'b1;
				tx   <= 1'b0; // start bit
				div  <= DIV_W'(`UART_CLKS_PER_BIT - 1);
				bitn <= '0;
			end
		end else if (div != '0) begin
			div <= div - 1'b1;
		end else begin
			div <= DIV_W'(`UART_CLKS_PER_BIT - 1);
			if (bitn == 4'd9) begin
				busy <= 1'b0;
				tx   <= 1'b1;
			end else begin
				tx   <= shreg[0];
				bitn <= bitn + 4'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!busy && tx_start) begin
			shreg <= {1'b1, tx_byte};
		end else if (busy && (div == '0)) begin
			shreg <= shreg >> 1;
		end
	end

endmodule
